//--- verilog/div_macros.svh
`ifndef DIV_MACROS_SVH
`define DIV_MACROS_SVH

// Operand and result width of the whole divide unit
`define DIV_WIDTH 32

// Iteration counter, wide enough to count DIV_WIDTH steps
`define DIV_COUNT_WIDTH 6

// Index of the sign bit
`define DIV_MSB (`DIV_WIDTH - 1)

`endif

//--- verilog/div_pkg.sv
`default_nettype none

`include "div_macros.svh"

package div_pkg;

    typedef logic [`DIV_WIDTH-1:0] div_word_t;

    typedef logic [`DIV_COUNT_WIDTH-1:0] div_count_t;

    // Low two bits of the M-extension funct3
    typedef enum logic [1:0] {
        DIV  = 2'b00,
        DIVU = 2'b01,
        REM  = 2'b10,
        REMU = 2'b11
    } div_op_t;

    typedef enum logic {
        IDLE = 1'b0,
        BUSY = 1'b1
    } div_state_t;

endpackage

`default_nettype wire

//--- verilog/div_unsigned_core.sv
`default_nettype none

`include "div_macros.svh"

module div_unsigned_core (
    input  wire                clk,
    input  wire                rst,
    input  wire                start,
    input  wire div_pkg::div_word_t dividend,
    input  wire div_pkg::div_word_t divisor,
    output logic               ready,
    output logic               valid,
    output logic               error,
    output div_pkg::div_word_t quotient,
    output div_pkg::div_word_t remainder
);

    div_pkg::div_state_t state;
    div_pkg::div_count_t count;
    logic                zero_div_q;
    logic                accept;

    div_pkg::div_word_t  divisor_q;
    div_pkg::div_word_t  quo_q;
    div_pkg::div_word_t  rem_q;

    logic [`DIV_WIDTH:0] partial;
    logic [`DIV_WIDTH:0] diff;

    assign accept = start && (state == div_pkg::IDLE);

    // Partial remainder with the next dividend bit shifted in
    assign partial = {rem_q, quo_q[`DIV_MSB]};
    assign diff    = partial - {1'b0, divisor_q};

    assign ready     = (state == div_pkg::IDLE);
    assign error     = valid && zero_div_q;
    assign quotient  = quo_q;
    assign remainder = rem_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            state      <= div_pkg::IDLE;
            count      <= '0;
            valid      <= 1'b0;
            zero_div_q <= 1'b0;
        end else begin
            valid <= 1'b0;
            case (state)
                div_pkg::IDLE: begin
                    if (accept) begin
                        state      <= div_pkg::BUSY;
                        count      <= '0;
                        zero_div_q <= (divisor == '0);
                    end
                end
                div_pkg::BUSY: begin
                    count <= count + 1'b1;
                    // Last quotient bit lands on this edge
                    if (count == div_pkg::div_count_t'(`DIV_WIDTH - 1)) begin
                        state <= div_pkg::IDLE;
                        valid <= 1'b1;
                    end
                end
                default: begin
                    state <= div_pkg::IDLE;
                end
            endcase
        end
    end

    // Quotient register starts out holding the dividend and
    // fills with quotient bits from the right
    always_ff @(posedge clk) begin
        if (accept) begin
            divisor_q <= divisor;
            quo_q     <= dividend;
            rem_q     <= '0;
        end else if (state == div_pkg::BUSY) begin
            if (!diff[`DIV_WIDTH]) begin
                rem_q <= diff[`DIV_MSB:0];
                quo_q <= {quo_q[`DIV_MSB-1:0], 1'b1};
            end else begin
                rem_q <= partial[`DIV_MSB:0];
                quo_q <= {quo_q[`DIV_MSB-1:0], 1'b0};
            end
        end
    end

endmodule

`default_nettype wire

//--- verilog/div_signed.sv
`default_nettype none

`include "div_macros.svh"

module div_signed (
    input  wire                clk,
    input  wire                rst,
    input  wire                start,
    input  wire                is_signed,
    input  wire div_pkg::div_word_t dividend,
    input  wire div_pkg::div_word_t divisor,
    output logic               ready,
    output logic               valid,
    output logic               error,
    output div_pkg::div_word_t quotient,
    output div_pkg::div_word_t remainder
);

    div_pkg::div_state_t state;
    logic                quo_neg_q;
    logic                rem_neg_q;
    logic                accept;

    logic                dividend_neg;
    logic                divisor_neg;
    div_pkg::div_word_t  abs_dividend;
    div_pkg::div_word_t  abs_divisor;
    div_pkg::div_word_t  core_quotient;
    div_pkg::div_word_t  core_remainder;

    assign dividend_neg = is_signed && dividend[`DIV_MSB];
    assign divisor_neg  = is_signed && divisor[`DIV_MSB];

    // Most negative value maps to itself, which is its magnitude unsigned
    assign abs_dividend = dividend_neg ? '0 - dividend : dividend;
    assign abs_divisor  = divisor_neg ? '0 - divisor : divisor;

    assign accept = start && ready;

    div_unsigned_core i_div_unsigned_core (
        .clk       (clk),
        .rst       (rst),
        .start     (start),
        .dividend  (abs_dividend),
        .divisor   (abs_divisor),
        .ready     (ready),
        .valid     (valid),
        .error     (error),
        .quotient  (core_quotient),
        .remainder (core_remainder)
    );

    // Divide by zero keeps the all-ones quotient, remainder gets its sign back
    assign quotient  = (quo_neg_q && !error) ? '0 - core_quotient : core_quotient;
    assign remainder = rem_neg_q ? '0 - core_remainder : core_remainder;

    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= div_pkg::IDLE;
            quo_neg_q <= 1'b0;
            rem_neg_q <= 1'b0;
        end else begin
            case (state)
                div_pkg::IDLE: begin
                    if (accept) begin
                        state     <= div_pkg::BUSY;
                        quo_neg_q <= dividend_neg ^ divisor_neg;
                        rem_neg_q <= dividend_neg;
                    end
                end
                div_pkg::BUSY: begin
                    // Core is ready again in its valid cycle
                    if (valid) begin
                        if (accept) begin
                            quo_neg_q <= dividend_neg ^ divisor_neg;
                            rem_neg_q <= dividend_neg;
                        end else begin
                            state <= div_pkg::IDLE;
                        end
                    end
                end
                default: begin
                    state <= div_pkg::IDLE;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

//--- verilog/div_unit.sv
`default_nettype none

module div_unit (
    input  wire                clk,
    input  wire                rst,
    input  wire                start,
    input  wire div_pkg::div_op_t   op,
    input  wire div_pkg::div_word_t dividend,
    input  wire div_pkg::div_word_t divisor,
    output logic               ready,
    output logic               valid,
    output logic               error,
    output div_pkg::div_word_t result
);

    logic               busy;
    logic               want_rem_q;
    logic               accept;
    logic               is_signed;
    logic               want_rem;

    logic               sub_ready;
    logic               sub_valid;
    logic               sub_error;
    div_pkg::div_word_t sub_quotient;
    div_pkg::div_word_t sub_remainder;

    // Stays low through the inner valid cycle until the result is registered
    assign ready  = !busy && sub_ready;
    assign accept = start && ready;

    assign is_signed = (op == div_pkg::DIV) || (op == div_pkg::REM);
    assign want_rem  = (op == div_pkg::REM) || (op == div_pkg::REMU);

    div_signed i_div_signed (
        .clk       (clk),
        .rst       (rst),
        .start     (accept),
        .is_signed (is_signed),
        .dividend  (dividend),
        .divisor   (divisor),
        .ready     (sub_ready),
        .valid     (sub_valid),
        .error     (sub_error),
        .quotient  (sub_quotient),
        .remainder (sub_remainder)
    );

    always_ff @(posedge clk) begin
        if (rst) begin
            busy       <= 1'b0;
            want_rem_q <= 1'b0;
            valid      <= 1'b0;
            error      <= 1'b0;
            result     <= '0;
        end else begin
            valid <= 1'b0;
            error <= 1'b0;
            if (accept) begin
                busy       <= 1'b1;
                want_rem_q <= want_rem;
            end else if (busy && sub_valid) begin
                busy  <= 1'b0;
                valid <= 1'b1;
                error <= sub_error;
                // Held here until the next operation completes
                result <= want_rem_q ? sub_remainder : sub_quotient;
            end
        end
    end

endmodule

`default_nettype wire

//--- dv/div_unit_sva.sv
`default_nettype none

module div_unit_sva (
    input wire clk,
    input wire rst,
    input wire start,
    input wire ready,
    input wire valid
);

    logic       in_flight;
    logic [6:0] since_start;

    // All ones means no start seen yet
    always_ff @(posedge clk) begin
        if (rst) begin
            in_flight   <= 1'b0;
            since_start <= '1;
        end else if (start && ready) begin
            in_flight   <= 1'b1;
            since_start <= '0;
        end else begin
            if (valid) begin
                in_flight <= 1'b0;
            end
            if (since_start != '1) begin
                since_start <= since_start + 7'd1;
            end
        end
    end

    valid_single: assert property (@(posedge clk) disable iff (rst) valid |=> !valid)
        else $error("valid high two cycles running");

    ready_low_busy: assert property (@(posedge clk) disable iff (rst)
        in_flight && !valid |-> !ready)
        else $error("ready high while an operation is in flight");

    // Result registered 33 edges after the accepting edge
    valid_latency: assert property (@(posedge clk) disable iff (rst)
        valid |-> since_start == 7'd33)
        else $error("valid not 33 cycles after accepted start");

endmodule

`default_nettype wire

//--- dv/div_unit_tb.sv
`default_nettype none

`include "div_macros.svh"

module div_unit_tb;

    localparam int PERIOD       = 20;
    localparam int RESET_CYCLES = 16;
    localparam int LATENCY      = 33;
    localparam int N_DIRECTED   = 16;
    localparam int N_RANDOM     = 60;
    localparam int TIMEOUT      = ((N_DIRECTED + N_RANDOM) * 40 + RESET_CYCLES) * PERIOD;

    logic               clk;
    logic               rst;
    logic               start;
    div_pkg::div_op_t   op;
    div_pkg::div_word_t dividend;
    div_pkg::div_word_t divisor;
    logic               ready;
    logic               valid;
    logic               error;
    div_pkg::div_word_t result;

    int                  seed;
    int                  errors;
    int                  checks;
    int                  cycle;
    int                  start_cycle;
    logic [`DIV_WIDTH:0] expected_q[$];

    div_unit i_div_unit (
        .clk      (clk),
        .rst      (rst),
        .start    (start),
        .op       (op),
        .dividend (dividend),
        .divisor  (divisor),
        .ready    (ready),
        .valid    (valid),
        .error    (error),
        .result   (result)
    );

    bind div_unit div_unit_sva i_div_unit_sva (
        .clk   (clk),
        .rst   (rst),
        .start (start),
        .ready (ready),
        .valid (valid)
    );

    // RISC-V M-extension result, error flag in the top bit
    function automatic logic [`DIV_WIDTH:0] expected_result(input div_pkg::div_op_t o,
                                                            input div_pkg::div_word_t a,
                                                            input div_pkg::div_word_t b);
        logic signed [`DIV_WIDTH-1:0] sa;
        logic signed [`DIV_WIDTH-1:0] sb;
        logic                         overflow;
        sa = a;
        sb = b;
        overflow = (a == {1'b1, {(`DIV_WIDTH-1){1'b0}}}) && (b == {`DIV_WIDTH{1'b1}});
        if (b == '0) begin
            if (o == div_pkg::DIV || o == div_pkg::DIVU) begin
                return {1'b1, {`DIV_WIDTH{1'b1}}};
            end
            return {1'b1, a};
        end
        case (o)
            div_pkg::DIVU: return {1'b0, a / b};
            div_pkg::REMU: return {1'b0, a % b};
            div_pkg::DIV:  return overflow ? {1'b0, a} : {1'b0, div_pkg::div_word_t'(sa / sb)};
            default:       return overflow ? '0 : {1'b0, div_pkg::div_word_t'(sa % sb)};
        endcase
    endfunction

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    always @(posedge clk) begin : compare
        logic [`DIV_WIDTH:0] exp_v;
        cycle = cycle + 1;
        if (!rst) begin
            if (error && !valid) begin
                $display("error flag raised outside a valid pulse");
                errors++;
            end
            if (valid) begin
                if (expected_q.size() == 0) begin
                    $display("valid pulse arrived with no operation pending");
                    errors++;
                end else begin
                    exp_v = expected_q.pop_front();
                    checks++;
                    if (result !== exp_v[`DIV_MSB:0]) begin
                        $display("Fail result: got 0x%h expected 0x%h",
                                 result, exp_v[`DIV_MSB:0]);
                        errors++;
                    end
                    if (error !== exp_v[`DIV_WIDTH]) begin
                        $display("Fail error: got 0x%h expected 0x%h", error, exp_v[`DIV_WIDTH]);
                        errors++;
                    end
                    // Valid registered 33 edges after start shows up at the next edge
                    if (cycle - start_cycle != LATENCY + 1) begin
                        $display("Fail valid latency: got 0x%h expected 0x%h",
                                 cycle - start_cycle - 1, LATENCY);
                        errors++;
                    end
                end
            end
            if (start && ready) begin
                expected_q.push_back(expected_result(op, dividend, divisor));
                start_cycle = cycle;
            end
        end
    end

    task automatic run_op(input div_pkg::div_op_t o, input div_pkg::div_word_t a,
                          input div_pkg::div_word_t b);
        while (!ready) @(posedge clk);
        start    <= 1'b1;
        op       <= o;
        dividend <= a;
        divisor  <= b;
        @(posedge clk);
        start <= 1'b0;
        @(posedge clk);
        while (!valid) @(posedge clk);
    endtask

    task automatic run_signed_pair(input div_pkg::div_word_t a, input div_pkg::div_word_t b);
        run_op(div_pkg::DIV, a, b);
        run_op(div_pkg::REM, a, b);
    endtask

    // Second start lands mid-operation and must be dropped
    task automatic run_with_busy_start(input div_pkg::div_op_t o, input div_pkg::div_word_t a,
                                       input div_pkg::div_word_t b);
        while (!ready) @(posedge clk);
        start    <= 1'b1;
        op       <= o;
        dividend <= a;
        divisor  <= b;
        @(posedge clk);
        start <= 1'b0;
        repeat (5) @(posedge clk);
        start    <= 1'b1;
        op       <= div_pkg::REMU;
        dividend <= ~a;
        divisor  <= 32'd3;
        @(posedge clk);
        start <= 1'b0;
        while (!valid) @(posedge clk);
    endtask

    initial begin
        #(TIMEOUT);
        $display("Timeout: run did not finish within %0d time units", TIMEOUT);
        $display("SOME TESTS FAILED");
        $finish;
    end

    initial begin : stimulus
        logic [31:0]        r;
        div_pkg::div_word_t a;
        div_pkg::div_word_t b;
        div_pkg::div_op_t   o;
        seed        = 38;
        errors      = 0;
        checks      = 0;
        cycle       = 0;
        start_cycle = 0;
        rst      = 1'b1;
        start    = 1'b0;
        op       = div_pkg::DIVU;
        dividend = '0;
        divisor  = '0;
        repeat (RESET_CYCLES) @(posedge clk);
        rst <= 1'b0;
        @(posedge clk);
        if (ready !== 1'b1 || valid !== 1'b0 || result !== '0) begin
            $display("Fail reset state: ready 0x%h valid 0x%h result 0x%h", ready, valid, result);
            errors++;
        end

        run_signed_pair(32'd1000003, 32'd97);
        run_signed_pair(-32'd1000003, 32'd97);
        run_signed_pair(32'd1000003, -32'd97);
        run_signed_pair(-32'd1000003, -32'd97);

        run_op(div_pkg::DIV, 32'h8765_4321, 32'd0);
        run_op(div_pkg::DIVU, 32'h8765_4321, 32'd0);
        run_op(div_pkg::REM, 32'h8765_4321, 32'd0);
        run_op(div_pkg::REMU, 32'h1234_5678, 32'd0);

        run_op(div_pkg::DIV, 32'h8000_0000, 32'hffff_ffff);
        run_op(div_pkg::REM, 32'h8000_0000, 32'hffff_ffff);

        run_with_busy_start(div_pkg::DIVU, 32'd5000, 32'd13);

        // 1000 / 7 truncates to 142
        run_op(div_pkg::DIVU, 32'd1000, 32'd7);
        repeat (10) @(posedge clk);
        if (result !== 32'd142) begin
            $display("Fail result hold: got 0x%h expected 0x%h", result, 32'd142);
            errors++;
        end

        for (int i = 0; i < N_RANDOM; i++) begin
            r = $random(seed);
            a = $random(seed);
            b = $random(seed);
            b = b >> r[6:2];
            if (i < N_RANDOM / 2) begin
                o = r[0] ? div_pkg::DIVU : div_pkg::REMU;
            end else begin
                o = div_pkg::div_op_t'(r[1:0]);
            end
            run_op(o, a, b);
        end

        repeat (2) @(posedge clk);
        if (expected_q.size() != 0) begin
            $display("%0d operations never returned a result", expected_q.size());
            errors++;
        end
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- verilog.f
+incdir+verilog
verilog/div_pkg.sv
verilog/div_unsigned_core.sv
verilog/div_signed.sv
verilog/div_unit.sv
dv/div_unit_sva.sv
dv/div_unit_tb.sv

//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert
TOP       = div_unit_tb
FILELIST  = verilog.f
OBJ_DIR   = obj_dir

SOURCES = $(filter-out +%,$(shell cat $(FILELIST))) $(wildcard verilog/*.svh)
SIM     = $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(SIM)

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -q "^ALL TESTS PASSED$$"

clean:
	rm -rf $(OBJ_DIR)
